// File: bench/asg_input.dat
# R sample readback (hex) | T addr sample (hex) | S sample amp dc dac (decimal)
# C and E ofs entries samples | B entries ncyc last | Z cycles (decimal)
R 0000 00000000
R 1fff 00001fff
R 2000 ffffe000
R 3fff ffffffff
R 0abc 00000abc
R 2abc ffffeabc
R 3000 fffff000
R 2001 ffffe001
T 0 0100
T 1 0350
T 2 0a00
T 3 1234
T 4 3f00
T 5 2abc
T 6 0777
T 7 1fff
T 14 0000
S 1000 8192 0 1000
S 1000 4096 100 600
S -1000 4096 0 -500
S -1001 4096 0 -501
S 3000 16383 -2000 3999
S 6000 12288 0 8191
S -6000 12288 0 -8192
S 8000 8192 500 8191
S -8000 8192 -500 -8192
S 123 8192 -123 0
C 2 8 20
B 4 2 -1234
Z 6
E 2 8 40

// File: list.f
+incdir+hdl
hdl/asg_pkg.sv
hdl/asg_ext_trig.sv
hdl/asg_burst_ctrl.sv
hdl/asg_table.sv
hdl/asg_out_scale.sv
hdl/asg_channel.sv
bench/asg_checker.sv
bench/asg_tb.sv

// File: run_sim.sh
#!/bin/bash
# build and run the channel testbench, fail on the fail message in the log
cd "$(dirname "$0")" || exit 1
set -o pipefail
verilator --binary --timing --assert -Wno-fatal --top-module asg_tb -f list.f -o asg_sim \
  && ./obj_dir/asg_sim 2>&1 | tee sim.log \
  || exit 1
grep -qF "*** TEST FAILED ***" sim.log && exit 1 || exit 0

// File: bench/asg_tb.sv
`timescale 1ns/1ns

`include "asg_config.svh"

module asg_tb;

  localparam int AW = `ASG_TBL_AW;
  localparam int DW = `ASG_DAC_W;
  localparam int PW = `ASG_PNT_W;
  localparam int FW = `ASG_FRAC_W;
  localparam int PARK = 20;  // pointer rests on this zero entry between tests

  logic                  clk, rstn;
  asg_pkg::asg_seq_cfg_t seq_cfg;
  asg_pkg::asg_out_cfg_t out_cfg;
  asg_pkg::asg_tbl_wr_t  tbl_wr;
  logic [AW-1:0]         buf_addr, buf_rpnt;
  logic                  trig_sw, trig_ext, trig_done;
  logic [DW-1:0]         dac;
  logic [31:0]           buf_rdata;

  logic [DW-1:0] tbl_model [1 << AW];  // shadow of the sample RAM
  logic [31:0]   rnd;                  // xorshift state
  int            errors, timeouts, done_cnt;

  asg_channel UUT (
    .dac_clk_i   (clk),
    .dac_rstn_i  (rstn),
    .seq_cfg_i   (seq_cfg),
    .out_cfg_i   (out_cfg),
    .tbl_wr_i    (tbl_wr),
    .buf_addr_i  (buf_addr),
    .trig_sw_i   (trig_sw),
    .trig_ext_i  (trig_ext),
    .dac_o       (dac),
    .trig_done_o (trig_done),
    .buf_rdata_o (buf_rdata),
    .buf_rpnt_o  (buf_rpnt)
  );

  bind asg_channel asg_checker u_checker (
    .dac_clk_i   (dac_clk_i),
    .dac_rstn_i  (dac_rstn_i),
    .seq_cfg_i   (seq_cfg_i),
    .out_cfg_i   (out_cfg_i),
    .burst_st_i  (u_burst_ctrl.burst_st_q),
    .rd_addr_i   (rd_addr),
    .dac_i       (dac_o),
    .trig_done_i (trig_done_o)
  );

  always #20 clk = ~clk;  // 40 ns period

  initial begin
    #1_000_000;
    $display("Simulation ran past its time limit");
    $display("*** TEST FAILED ***");
    $finish;
  end

  // ---------------------------------------------------------------------
  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  function automatic int sx(logic [DW-1:0] v);
    return int'($signed(v));  // dac code as signed int
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;
  endtask

  task automatic check(string name, int exp, int got);
    assert (exp == got) else begin
      errors++;
      $display("Fail %s: expected %0d, got %0d", name, exp, got);
    end
  endtask

  task automatic set_seq(int ofs, int n, bit rst, int ncyc, asg_pkg::trig_src_e src);
    seq_cfg.ofs      = PW'(ofs) << FW;
    seq_cfg.size     = (PW'(n) << FW) - PW'(1);  // last entry with fraction all ones
    seq_cfg.step     = PW'(1) << FW;             // 1.0
    seq_cfg.wrap     = 1'b1;
    seq_cfg.rst      = rst;
    seq_cfg.ncyc     = 16'(ncyc);
    seq_cfg.rnum     = '0;
    seq_cfg.rdly     = '0;
    seq_cfg.trig_src = src;
  endtask

  task automatic set_out(int amp, int dc, int last, bit zero);
    out_cfg.amp  = DW'(amp);
    out_cfg.dc   = DW'(dc);
    out_cfg.last = DW'(last);
    out_cfg.zero = zero;
  endtask

  task automatic table_write(int addr, int data);
    tick();
    tbl_wr.we    = 1'b1;
    tbl_wr.addr  = AW'(addr);
    tbl_wr.wdata = DW'(data);
    tbl_model[AW'(addr)] = DW'(data);
    tick();
    tbl_wr.we = 1'b0;
  endtask

  // hold pointer on the zero entry at unity gain
  task automatic park();
    tick();
    set_seq(PARK, 1 << AW, 1'b1, 0, asg_pkg::trig_none);
    set_out(8192, 0, 0, 1'b0);
    repeat (3) tick();
  endtask

  task automatic sw_trigger();
    trig_sw = 1'b1;
    tick();
    trig_sw = 1'b0;
  endtask

  // spin until dac shows the first expected sample
  task automatic wait_sample(string name, int exp);
    int t;
    t = 0;
    do begin
      @(negedge clk);
      t++;
      if (trig_done)
        done_cnt++;
    end while (sx(dac) != exp && t < 40);
    assert (sx(dac) == exp) else begin
      timeouts++;
      $display("Timeout: first sample never reached dac in %s", name);
    end
  endtask

  // ---------------------------------------------------------------------
  task automatic readback(int sample, int exp);
    logic [AW-1:0] addr;
    rnd  = xorshift(rnd);
    addr = rnd[AW-1:0];
    table_write(addr, sample);
    buf_addr = addr;
    @(posedge clk);
    @(negedge clk);  // one clock after the address
    check("readback", exp, buf_rdata);
  endtask

  task automatic scale(int sample, int amp, int dc, int exp);
    tick();
    set_seq(30, 1 << AW, 1'b1, 0, asg_pkg::trig_none);
    set_out(amp, dc, 0, 1'b0);
    table_write(30, sample);
    repeat (8) @(posedge clk);  // table 2 plus output 3 plus margin
    @(negedge clk);
    check("scale", exp, sx(dac));
    check("read pointer", 30, buf_rpnt);  // rst holds the pointer on ofs
  endtask

  task automatic continuous(int ofs, int n, int count);
    park();
    set_seq(ofs, n, 1'b0, 0, asg_pkg::trig_sw);
    sw_trigger();
    wait_sample("continuous", sx(tbl_model[ofs]));
    for (int i = 1; i < count; i++) begin
      @(negedge clk);
      check("continuous", sx(tbl_model[(ofs + i) % n]), sx(dac));
    end
  endtask

  task automatic burst(int n, int ncyc, int last);
    int t;
    park();
    set_seq(0, n, 1'b0, ncyc, asg_pkg::trig_sw);
    set_out(8192, 0, last, 1'b0);
    sw_trigger();
    t = 0;
    do begin
      @(negedge clk);
      t++;
    end while (!trig_done && t < 20);
    assert (trig_done) else begin
      timeouts++;
      $display("Timeout: trig_done never rose after the software trigger");
    end
    done_cnt = 1;
    for (int i = 1; i < 16 + n * ncyc; i++) begin
      @(negedge clk);
      if (trig_done)
        done_cnt++;
      if (i >= 6 && i < 6 + n * ncyc)   // 7 clocks from trigger to dac
        check("burst sample", sx(tbl_model[(i - 6) % n]), sx(dac));
      else if (i >= 6 + n * ncyc)
        check("burst last", sx(DW'(last)), sx(dac));
    end
    check("burst trig_done pulses", 1, done_cnt);
  endtask

  task automatic zero_out(int cycles);
    tick();
    out_cfg.zero = 1'b1;
    repeat (2) @(posedge clk);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      check("zero", 0, sx(dac));
    end
  endtask

  // second rising edge lands inside the hold-off
  task automatic ext_start(int ofs, int n, int count);
    park();
    set_seq(ofs, n, 1'b0, 0, asg_pkg::trig_ext_pos);
    trig_ext = 1'b1;
    done_cnt = 0;
    wait_sample("ext trigger", sx(tbl_model[ofs]));
    for (int i = 1; i < count; i++) begin
      @(negedge clk);
      if (trig_done)
        done_cnt++;
      check("ext playback", sx(tbl_model[(ofs + i) % n]), sx(dac));
      if (i == 10 || i == 20) begin
        tick();
        trig_ext = (i == 20);
      end
    end
    check("ext trig_done pulses", 1, done_cnt);
  endtask

  // ---------------------------------------------------------------------
  initial begin
    int    fd, a, b, c, d;
    string line, args;
    clk      = 1'b0;
    rstn     = 1'b0;
    seq_cfg  = '0;
    out_cfg  = '0;
    tbl_wr   = '0;
    buf_addr = '0;
    trig_sw  = 1'b0;
    trig_ext = 1'b0;
    rnd      = 32'd18246;
    errors   = 0;
    timeouts = 0;
    done_cnt = 0;
    repeat (4) @(posedge clk);
    #2 rstn = 1'b1;

    fd = $fopen("bench/asg_input.dat", "r");
    assert (fd != 0) else begin
      errors++;
      $display("Could not open bench/asg_input.dat");
    end
    while (fd != 0 && $fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#")
        continue;
      args = line.substr(2, line.len() - 1);
      case (line[0])
        "R": begin
          void'($sscanf(args, "%h %h", a, b));
          readback(a, b);
        end
        "T": begin
          void'($sscanf(args, "%h %h", a, b));
          table_write(a, b);
        end
        "S": begin
          void'($sscanf(args, "%d %d %d %d", a, b, c, d));
          scale(a, b, c, d);
        end
        "C": begin
          void'($sscanf(args, "%d %d %d", a, b, c));
          continuous(a, b, c);
        end
        "B": begin
          void'($sscanf(args, "%d %d %d", a, b, c));
          burst(a, b, c);
        end
        "Z": begin
          void'($sscanf(args, "%d", a));
          zero_out(a);
        end
        "E": begin
          void'($sscanf(args, "%d %d %d", a, b, c));
          ext_start(a, b, c);
        end
        default: begin
          errors++;
          $display("Unknown record in the input file: %s", line);
        end
      endcase
    end
    if (fd != 0)
      $fclose(fd);

    $display("Checks failed: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0)
      $display("*** TEST PASSED ***");
    else
      $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

// File: bench/asg_checker.sv
`timescale 1ns/1ns

`include "asg_config.svh"

module asg_checker (
  input logic                   dac_clk_i,
  input logic                   dac_rstn_i,
  input asg_pkg::asg_seq_cfg_t  seq_cfg_i,
  input asg_pkg::asg_out_cfg_t  out_cfg_i,
  input asg_pkg::burst_state_e  burst_st_i,
  input logic [`ASG_TBL_AW-1:0] rd_addr_i,
  input logic [`ASG_DAC_W-1:0]  dac_i,
  input logic                   trig_done_i
);

  // ---------------------------------------------------------------------
  a_done_in_reset: assert property (@(posedge dac_clk_i)
    !dac_rstn_i ##1 !dac_rstn_i |-> !trig_done_i)
    else $error("trig_done_o high during reset");

  // output register forced low by zero
  a_zero_out: assert property (@(posedge dac_clk_i) disable iff (!dac_rstn_i)
    out_cfg_i.zero [*3] |-> (dac_i == '0))
    else $error("dac_o not zero with zero set");

  a_idle_hold: assert property (@(posedge dac_clk_i) disable iff (!dac_rstn_i)
    (burst_st_i == asg_pkg::st_idle) && !trig_done_i |=> (burst_st_i == asg_pkg::st_idle))
    else $error("sequencer left idle without a trigger");

  a_addr_range: assert property (@(posedge dac_clk_i) disable iff (!dac_rstn_i)
    (burst_st_i == asg_pkg::st_run) |-> (rd_addr_i <= seq_cfg_i.size[`ASG_PNT_W-1:`ASG_FRAC_W]))
    else $error("read address beyond table size while running");

endmodule

// File: hdl/asg_channel.sv
`timescale 1ns/1ns

`include "asg_config.svh"

module asg_channel (
  input  logic                   dac_clk_i,
  input  logic                   dac_rstn_i,
  // configuration, held in the register bank
  input  asg_pkg::asg_seq_cfg_t  seq_cfg_i,
  input  asg_pkg::asg_out_cfg_t  out_cfg_i,
  // table access from the system bus
  input  asg_pkg::asg_tbl_wr_t   tbl_wr_i,
  input  logic [`ASG_TBL_AW-1:0] buf_addr_i,
  // triggers
  input  logic                   trig_sw_i,
  input  logic                   trig_ext_i,
  // outputs
  output logic [`ASG_DAC_W-1:0]  dac_o,
  output logic                   trig_done_o,
  output logic [`ASG_BUS_DW-1:0] buf_rdata_o,
  output logic [`ASG_TBL_AW-1:0] buf_rpnt_o
);

  logic                   ext_pos, ext_neg;  // debounced edge pulses
  logic [`ASG_TBL_AW-1:0] rd_addr;
  logic [`ASG_DAC_W-1:0]  sample;
  logic                   last_hold;

  // ---------------------------------------------------------------------
  asg_ext_trig u_ext_trig (
    .dac_clk_i  (dac_clk_i),
    .dac_rstn_i (dac_rstn_i),
    .trig_ext_i (trig_ext_i),
    .ext_pos_o  (ext_pos),
    .ext_neg_o  (ext_neg)
  );

  asg_burst_ctrl u_burst_ctrl (
    .dac_clk_i   (dac_clk_i),
    .dac_rstn_i  (dac_rstn_i),
    .seq_cfg_i   (seq_cfg_i),
    .trig_sw_i   (trig_sw_i),
    .ext_pos_i   (ext_pos),
    .ext_neg_i   (ext_neg),
    .rd_addr_o   (rd_addr),
    .buf_rpnt_o  (buf_rpnt_o),
    .last_hold_o (last_hold),
    .trig_done_o (trig_done_o)
  );

  asg_table u_table (
    .dac_clk_i   (dac_clk_i),
    .tbl_wr_i    (tbl_wr_i),
    .buf_addr_i  (buf_addr_i),
    .buf_rdata_o (buf_rdata_o),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (sample)
  );

  asg_out_scale u_out_scale (
    .dac_clk_i   (dac_clk_i),
    .out_cfg_i   (out_cfg_i),
    .sample_i    (sample),
    .last_hold_i (last_hold),
    .dac_o       (dac_o)
  );

endmodule

// File: hdl/asg_out_scale.sv
`timescale 1ns/1ns

`include "asg_config.svh"

module asg_out_scale (
  input  logic                  dac_clk_i,
  input  asg_pkg::asg_out_cfg_t out_cfg_i,
  input  logic [`ASG_DAC_W-1:0] sample_i,     // signed table sample
  input  logic                  last_hold_i,
  output logic [`ASG_DAC_W-1:0] dac_o
);

  localparam int DW    = `ASG_DAC_W;
  localparam int MUL_W = 2 * DW;

  logic signed [MUL_W-1:0] mult_q;  // sample * amp, amp 0x2000 = 1.0
  logic signed [DW:0]      sum_q;   // one guard bit for saturation
  logic        [DW-1:0]    sat;
  logic                    last_arm_q;

  // ---------------------------------------------------------------------
  // gain and offset
  always_ff @(posedge dac_clk_i) begin
    mult_q <= MUL_W'($signed(sample_i) * $signed({1'b0, out_cfg_i.amp}));
    sum_q  <= $signed(mult_q[MUL_W-1:DW-1])
            + $signed({out_cfg_i.dc[DW-1], out_cfg_i.dc});
  end

  // clamp to -2^(DW-1) .. 2^(DW-1)-1
  always_comb begin
    if (sum_q[DW] != sum_q[DW-1])
      sat = {sum_q[DW], {(DW-1){~sum_q[DW]}}};
    else
      sat = sum_q[DW-1:0];
  end

  // zero drops the held last value until the sequencer releases it
  always_ff @(posedge dac_clk_i) begin
    if (out_cfg_i.zero)
      last_arm_q <= 1'b0;
    else if (!last_hold_i)
      last_arm_q <= 1'b1;
  end

  // ---------------------------------------------------------------------
  // output select
  always_ff @(posedge dac_clk_i) begin
    if (out_cfg_i.zero)
      dac_o <= '0;
    else if (last_hold_i && last_arm_q)
      dac_o <= out_cfg_i.last;   // after final burst
    else
      dac_o <= sat;
  end

endmodule

// File: hdl/asg_table.sv
`timescale 1ns/1ns

`include "asg_config.svh"

module asg_table (
  input  logic                   dac_clk_i,
  input  asg_pkg::asg_tbl_wr_t   tbl_wr_i,     // bus write strobe
  input  logic [`ASG_TBL_AW-1:0] buf_addr_i,   // bus readback address
  output logic [`ASG_BUS_DW-1:0] buf_rdata_o,  // sign-extended sample
  input  logic [`ASG_TBL_AW-1:0] rd_addr_i,    // playback pointer
  output logic [`ASG_DAC_W-1:0]  rd_data_o
);

  localparam int DW    = `ASG_DAC_W;
  localparam int DEPTH = 1 << `ASG_TBL_AW;

  logic [DW-1:0] mem [DEPTH];
  logic [DW-1:0] bus_rd;
  logic [DW-1:0] play_rd_q;  // first playback stage

  // ---------------------------------------------------------------------
  // single write port from the bus
  always_ff @(posedge dac_clk_i) begin
    if (tbl_wr_i.we)
      mem[tbl_wr_i.addr] <= tbl_wr_i.wdata;
  end

  // bus readback, one clock
  assign bus_rd = mem[buf_addr_i];

  always_ff @(posedge dac_clk_i) begin
    buf_rdata_o <= {{(`ASG_BUS_DW - DW){bus_rd[DW-1]}}, bus_rd};
  end

  // playback, two clocks
  always_ff @(posedge dac_clk_i) begin
    play_rd_q <= mem[rd_addr_i];
    rd_data_o <= play_rd_q;   // extra stage for routing to the multiplier
  end

endmodule

// File: hdl/asg_burst_ctrl.sv
`timescale 1ns/1ns

`include "asg_config.svh"

module asg_burst_ctrl (
  input  logic                   dac_clk_i,
  input  logic                   dac_rstn_i,
  input  asg_pkg::asg_seq_cfg_t  seq_cfg_i,
  input  logic                   trig_sw_i,
  input  logic                   ext_pos_i,
  input  logic                   ext_neg_i,
  output logic [`ASG_TBL_AW-1:0] rd_addr_o,    // integer part of pointer
  output logic [`ASG_TBL_AW-1:0] buf_rpnt_o,   // pointer as seen by the bus
  output logic                   last_hold_o,  // play the user last value
  output logic                   trig_done_o   // accepted trigger
);

  localparam int PW     = `ASG_PNT_W;
  localparam int FW     = `ASG_FRAC_W;
  localparam int TICK_W = `ASG_TICK_W;
  localparam int LD     = `ASG_LAST_DLY;
  localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(`ASG_TICK_CYC - 1);

  asg_pkg::burst_state_e burst_st_q;

  logic              trig_in_q;   // selected trigger, registered
  logic [15:0]       cyc_cnt_q;
  logic [15:0]       rep_cnt_q;
  logic [31:0]       dly_cnt_q;
  logic [TICK_W-1:0] tick_q;
  logic [PW-1:0]     pnt_q;
  logic [PW:0]       pnt_nxt;     // one bit of headroom
  logic [PW:0]       pnt_sub;     // sign bit set while inside the table
  logic [LD-1:0]     run_dly_q;
  logic              running, rep_act, trig_start, restart, dac_trig;
  logic              wrap_hit, cyc_end, not_burst;

  assign running    = (burst_st_q == asg_pkg::st_run);
  assign rep_act    = |rep_cnt_q && (running || (burst_st_q == asg_pkg::st_delay));
  assign trig_start = trig_in_q && !rep_act;  // triggers ignored mid-repetition
  assign restart    = (burst_st_q == asg_pkg::st_delay) && (dly_cnt_q == 32'd0);
  assign dac_trig   = trig_start || restart;
  assign not_burst  = (seq_cfg_i.ncyc == 16'd0) && (seq_cfg_i.rnum == 16'd0);

  assign trig_done_o = trig_start;

  // ---------------------------------------------------------------------
  // fixed point pointer
  assign pnt_nxt  = {1'b0, pnt_q} + {1'b0, seq_cfg_i.step};
  assign pnt_sub  = pnt_nxt - {1'b0, seq_cfg_i.size} - (PW+1)'(1);
  assign wrap_hit = ~pnt_sub[PW];          // passed size
  assign cyc_end  = (cyc_cnt_q == 16'd1) && wrap_hit;

  assign rd_addr_o = pnt_q[PW-1:FW];

  always_ff @(posedge dac_clk_i) begin
    buf_rpnt_o <= pnt_q[PW-1:FW];
    if (!dac_rstn_i)
      pnt_q <= '0;
    else if (seq_cfg_i.rst || (dac_trig && !running))
      pnt_q <= seq_cfg_i.ofs;              // manual reset or (re)start
    else if (running) begin
      if (wrap_hit)
        pnt_q <= seq_cfg_i.wrap ? pnt_sub[PW-1:0] : seq_cfg_i.ofs;
      else
        pnt_q <= pnt_nxt[PW-1:0];
    end
  end

  // ---------------------------------------------------------------------
  // trigger select, counters and FSM
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      trig_in_q  <= 1'b0;
      cyc_cnt_q  <= '0;
      rep_cnt_q  <= '0;
      dly_cnt_q  <= '0;
      tick_q     <= '0;
      burst_st_q <= asg_pkg::st_idle;
    end else begin
      case (seq_cfg_i.trig_src)
        asg_pkg::trig_sw:      trig_in_q <= trig_sw_i;
        asg_pkg::trig_ext_pos: trig_in_q <= ext_pos_i;
        asg_pkg::trig_ext_neg: trig_in_q <= ext_neg_i;
        default:               trig_in_q <= 1'b0;
      endcase

      // 1 us tick, held at 0 while playing
      if (running || (tick_q == TICK_LAST))
        tick_q <= '0;
      else
        tick_q <= tick_q + TICK_W'(1);

      if (seq_cfg_i.rst || running)
        dly_cnt_q <= seq_cfg_i.rdly;
      else if (|dly_cnt_q && (tick_q == TICK_LAST))
        dly_cnt_q <= dly_cnt_q - 32'd1;

      if (seq_cfg_i.rst)
        rep_cnt_q <= '0;
      else if (trig_start)
        rep_cnt_q <= seq_cfg_i.rnum;
      else if (restart)
        rep_cnt_q <= rep_cnt_q - 16'd1;

      if (dac_trig)
        cyc_cnt_q <= seq_cfg_i.ncyc;
      else if (running && wrap_hit && |cyc_cnt_q)
        cyc_cnt_q <= cyc_cnt_q - 16'd1;    // one table pass done

      if (seq_cfg_i.rst)
        burst_st_q <= asg_pkg::st_idle;
      else if (dac_trig)
        burst_st_q <= asg_pkg::st_run;     // retrigger keeps running
      else if (running && cyc_end)
        burst_st_q <= |rep_cnt_q ? asg_pkg::st_delay : asg_pkg::st_last;
    end
  end

  // ---------------------------------------------------------------------
  // last value, delayed to match the output pipeline
  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      run_dly_q   <= '0;
      last_hold_o <= 1'b0;
    end else begin
      run_dly_q <= {run_dly_q[LD-2:0], running};
      if (run_dly_q[LD-1:LD-2] == 2'b10)
        last_hold_o <= 1'b1;               // final sample has left the dac
      if (dac_trig || seq_cfg_i.rst || not_burst)
        last_hold_o <= 1'b0;
    end
  end

endmodule

// File: hdl/asg_ext_trig.sv
`timescale 1ns/1ns

`include "asg_config.svh"

module asg_ext_trig (
  input  logic dac_clk_i,
  input  logic dac_rstn_i,
  input  logic trig_ext_i,  // asynchronous pin
  output logic ext_pos_o,   // one clock per qualified rising edge
  output logic ext_neg_o    // one clock per qualified falling edge
);

  localparam int DEB_W = `ASG_DEB_W;
  localparam logic [DEB_W-1:0] DEB_LOAD = DEB_W'(`ASG_DEBOUNCE_CYC);

  // index 0 is the rising path, 1 the falling path
  logic [2:0]       sync_q;      // [0] metastable, [2] oldest
  logic [DEB_W-1:0] deb_q [2];   // hold-off counters
  logic [1:0]       hist_q [2];  // {previous, current} admitted level
  logic [1:0]       chg;         // level change seen after the synchroniser

  assign chg[0] = sync_q[1] & ~sync_q[2];
  assign chg[1] = ~sync_q[1] & sync_q[2];

  always_ff @(posedge dac_clk_i) begin
    if (!dac_rstn_i) begin
      sync_q <= '0;
      for (int p = 0; p < 2; p++) begin
        deb_q[p]  <= '0;
        hist_q[p] <= '0;
      end
    end else begin
      sync_q <= {sync_q[1:0], trig_ext_i};

      for (int p = 0; p < 2; p++) begin
        // start hold-off on a fresh edge, only when idle
        if ((deb_q[p] == '0) && chg[p])
          deb_q[p] <= DEB_LOAD;
        else if (deb_q[p] != '0)
          deb_q[p] <= deb_q[p] - DEB_W'(1);

        hist_q[p][1] <= hist_q[p][0];
        if (deb_q[p] == '0)
          hist_q[p][0] <= sync_q[1];  // level frozen during hold-off
      end
    end
  end

  // ---------------------------------------------------------------------
  // edge pulses from the admitted level
  assign ext_pos_o = (hist_q[0] == 2'b01);
  assign ext_neg_o = (hist_q[1] == 2'b10);

endmodule

// File: hdl/asg_pkg.sv
package asg_pkg;

  `include "asg_config.svh"

  // ---------------------------------------------------------------------
  // trigger source, same codes as the register map
  typedef enum logic [2:0] {
    trig_none    = 3'd0,
    trig_sw      = 3'd1,  // write strobe from the bus
    trig_ext_pos = 3'd2,  // debounced rising edge
    trig_ext_neg = 3'd3   // debounced falling edge
  } trig_src_e;

  // burst sequencer
  typedef enum logic [1:0] {
    st_idle,   // after reset or rst
    st_run,    // pointer moving
    st_delay,  // waiting rdly ticks before next repetition
    st_last    // final burst done, holding last value
  } burst_state_e;

  // ---------------------------------------------------------------------
  // pointer and burst settings
  typedef struct packed {
    logic [`ASG_PNT_W-1:0] size;  // last valid pointer, fixed point
    logic [`ASG_PNT_W-1:0] step;  // pointer increment per clock
    logic [`ASG_PNT_W-1:0] ofs;   // start pointer
    logic                  wrap;  // keep fraction on wrap
    logic                  rst;   // hold sequencer in idle
    logic [15:0]           ncyc;  // table cycles per burst, 0 = endless
    logic [15:0]           rnum;  // repetitions after the first burst
    logic [31:0]           rdly;  // gap between bursts in 1 us ticks
    trig_src_e             trig_src;
  } asg_seq_cfg_t;

  // output stage settings
  typedef struct packed {
    logic        [`ASG_DAC_W-1:0] amp;   // 0x2000 is unity
    logic signed [`ASG_DAC_W-1:0] dc;
    logic        [`ASG_DAC_W-1:0] last;  // value after final burst
    logic                         zero;  // force output to 0
  } asg_out_cfg_t;

  // one-cycle table write strobe
  typedef struct packed {
    logic                  we;
    logic [`ASG_TBL_AW-1:0] addr;
    logic [`ASG_DAC_W-1:0]  wdata;
  } asg_tbl_wr_t;

endpackage

// File: hdl/asg_config.svh
`ifndef ASG_CONFIG_SVH
`define ASG_CONFIG_SVH

// ---------------------------------------------------------------------
// data path widths
`define ASG_DAC_W         14  // dac sample, two's complement
`define ASG_TBL_AW        14  // table address, 16k entries
`define ASG_FRAC_W        16  // pointer fraction bits
`define ASG_PNT_W         (`ASG_TBL_AW + `ASG_FRAC_W)

// ---------------------------------------------------------------------
// timing constants at 125 MHz
`define ASG_TICK_CYC      125    // clocks per 1 us delay tick
`define ASG_TICK_W        8      // holds ASG_TICK_CYC - 1
`define ASG_DEBOUNCE_CYC  62500  // ~0.5 ms hold-off on ext trigger
`define ASG_DEB_W         20     // holds ASG_DEBOUNCE_CYC

// pointer -> dac latency, lines up the last value with the final sample
`define ASG_LAST_DLY      4

// bus readback word
`define ASG_BUS_DW        32

`endif
